/* Makefile */
TOP := icache_bank_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/10ps -f sim.f --top-module $(TOP)

# Pass or fail is taken from the printed result
sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f sim.f \
		--top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* design/icache_arrays.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_arrays
(
   input  logic                                                  clk,
   input  logic                                                  rst_n,

   // Lookup read port
   input  logic                                                  rd_en_i,
   input  logic [icache_pkg::INDEX_W-1:0]                        rd_index_i,
   output icache_pkg::way_oh_t                                   way_valid_o,
   output logic [icache_pkg::NB_WAYS-1:0][icache_pkg::TAG_W-1:0] way_tag_o,
   output icache_pkg::line_t [icache_pkg::NB_WAYS-1:0]           way_line_o,

   // Refill write port
   input  logic                                                  wr_en_i,
   input  icache_pkg::way_oh_t                                   wr_way_i,
   input  logic [icache_pkg::INDEX_W-1:0]                        wr_index_i,
   input  logic [icache_pkg::TAG_W-1:0]                          wr_tag_i,
   input  icache_pkg::line_t                                     wr_line_i,

   input  logic                                                  flush_i
);
   import icache_pkg::*;

   // Tag and data storage, one entry per set and way
   logic [TAG_W-1:0]        tag_mem  [NB_SETS][NB_WAYS];
   line_t                   data_mem [NB_SETS][NB_WAYS];

   // Valid bits per set
   way_oh_t [NB_SETS-1:0]   valid_q;

   ////////////////////////////////////////////////////////////
   // Storage write and registered read
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      for (int w = 0; w < NB_WAYS; w++)
      begin
         // Only the chosen way of the set is written
         if (wr_en_i && wr_way_i[w])
         begin
            tag_mem[wr_index_i][w]  <= wr_tag_i;
            data_mem[wr_index_i][w] <= wr_line_i;
         end
         // Output holds while no lookup is issued
         if (rd_en_i)
         begin
            way_tag_o[w]  <= tag_mem[rd_index_i][w];
            way_line_o[w] <= data_mem[rd_index_i][w];
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Valid bits
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q     <= '0;
         way_valid_o <= '0;
      end
      else
      begin
         // Flush invalidates every line at once
         if (flush_i)
         begin
            valid_q <= '0;
         end
         else if (wr_en_i)
         begin
            valid_q[wr_index_i] <= valid_q[wr_index_i] | wr_way_i;
         end

         if (rd_en_i)
         begin
            way_valid_o <= valid_q[rd_index_i];
         end
      end
   end

endmodule

`default_nettype wire

/* design/icache_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_bank
(
   input  logic                             clk,
   input  logic                             rst_n,

   input  logic                             bypass_i,
   output logic                             cache_bypassed_o,

   // Fetch port
   input  logic                             fetch_req_i,
   input  logic [icache_pkg::ADDR_W-1:0]    fetch_addr_i,
   output logic                             fetch_gnt_o,
   output logic                             fetch_rvalid_o,
   output icache_pkg::line_t                fetch_rdata_o,

   // Wishbone classic read bus
   output logic                             wb_cyc_o,
   output logic                             wb_stb_o,
   output logic [icache_pkg::ADDR_W-1:0]    wb_adr_o,
   input  logic [icache_pkg::WB_DATA_W-1:0] wb_dat_i,
   input  logic                             wb_ack_i
);
   import icache_pkg::*;

   // Controller to arrays
   logic                              rd_en;
   logic [INDEX_W-1:0]                rd_index;
   way_oh_t                           way_valid;
   logic [NB_WAYS-1:0][TAG_W-1:0]     way_tag;
   line_t [NB_WAYS-1:0]               way_line;
   logic                              wr_en;
   way_oh_t                           wr_way;
   logic [INDEX_W-1:0]                wr_index;
   logic [TAG_W-1:0]                  wr_tag;
   line_t                             wr_line;
   logic                              flush;

   // Controller to victim selector
   way_oh_t                           victim_valid;
   way_oh_t                           victim_way;
   logic                              victim_take;

   // Shared by bypass reads and refills
   line_fill_if fill ();

   icache_ctrl u_ctrl
   (
      .clk              ( clk              ),
      .rst_n            ( rst_n            ),
      .bypass_i         ( bypass_i         ),
      .cache_bypassed_o ( cache_bypassed_o ),
      .fetch_req_i      ( fetch_req_i      ),
      .fetch_addr_i     ( fetch_addr_i     ),
      .fetch_gnt_o      ( fetch_gnt_o      ),
      .fetch_rvalid_o   ( fetch_rvalid_o   ),
      .fetch_rdata_o    ( fetch_rdata_o    ),
      .rd_en_o          ( rd_en            ),
      .rd_index_o       ( rd_index         ),
      .way_valid_i      ( way_valid        ),
      .way_tag_i        ( way_tag          ),
      .way_line_i       ( way_line         ),
      .wr_en_o          ( wr_en            ),
      .wr_way_o         ( wr_way           ),
      .wr_index_o       ( wr_index         ),
      .wr_tag_o         ( wr_tag           ),
      .wr_line_o        ( wr_line          ),
      .flush_o          ( flush            ),
      .victim_valid_o   ( victim_valid     ),
      .victim_way_i     ( victim_way       ),
      .victim_take_o    ( victim_take      ),
      .fill             ( fill             )
   );

   icache_arrays u_arrays
   (
      .clk         ( clk       ),
      .rst_n       ( rst_n     ),
      .rd_en_i     ( rd_en     ),
      .rd_index_i  ( rd_index  ),
      .way_valid_o ( way_valid ),
      .way_tag_o   ( way_tag   ),
      .way_line_o  ( way_line  ),
      .wr_en_i     ( wr_en     ),
      .wr_way_i    ( wr_way    ),
      .wr_index_i  ( wr_index  ),
      .wr_tag_i    ( wr_tag    ),
      .wr_line_i   ( wr_line   ),
      .flush_i     ( flush     )
   );

   icache_victim_sel u_victim_sel
   (
      .clk          ( clk          ),
      .rst_n        ( rst_n        ),
      .valid_i      ( victim_valid ),
      .take_i       ( victim_take  ),
      .victim_way_o ( victim_way   )
   );

   icache_wb_reader u_wb_reader
   (
      .clk      ( clk      ),
      .rst_n    ( rst_n    ),
      .fill     ( fill     ),
      .wb_cyc_o ( wb_cyc_o ),
      .wb_stb_o ( wb_stb_o ),
      .wb_adr_o ( wb_adr_o ),
      .wb_dat_i ( wb_dat_i ),
      .wb_ack_i ( wb_ack_i )
   );

endmodule

`default_nettype wire

/* design/icache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl
(
   input  logic                                                  clk,
   input  logic                                                  rst_n,

   // Mode control
   input  logic                                                  bypass_i,
   output logic                                                  cache_bypassed_o,

   // Fetch port
   input  logic                                                  fetch_req_i,
   input  logic [icache_pkg::ADDR_W-1:0]                         fetch_addr_i,
   output logic                                                  fetch_gnt_o,
   output logic                                                  fetch_rvalid_o,
   output icache_pkg::line_t                                     fetch_rdata_o,

   // Arrays
   output logic                                                  rd_en_o,
   output logic [icache_pkg::INDEX_W-1:0]                        rd_index_o,
   input  icache_pkg::way_oh_t                                   way_valid_i,
   input  logic [icache_pkg::NB_WAYS-1:0][icache_pkg::TAG_W-1:0] way_tag_i,
   input  icache_pkg::line_t [icache_pkg::NB_WAYS-1:0]           way_line_i,
   output logic                                                  wr_en_o,
   output icache_pkg::way_oh_t                                   wr_way_o,
   output logic [icache_pkg::INDEX_W-1:0]                        wr_index_o,
   output logic [icache_pkg::TAG_W-1:0]                          wr_tag_o,
   output icache_pkg::line_t                                     wr_line_o,
   output logic                                                  flush_o,

   // Victim selection
   output icache_pkg::way_oh_t                                   victim_valid_o,
   input  icache_pkg::way_oh_t                                   victim_way_i,
   output logic                                                  victim_take_o,

   // Line reads through the bus reader
   line_fill_if.initiator                                        fill
);
   import icache_pkg::*;

   icache_state_e state_q, state_d;

   // Lookup register
   logic          lookup_vld_q, lookup_vld_d;
   icache_addr_u  lookup_q;

   // Refill written, re-lookup still to issue
   logic          refilled_q, refilled_d;

   // Valid vector of the missed set
   way_oh_t       valid_snap_q;
   logic          snap_valid;

   // Address views
   icache_addr_u  fetch_addr;
   icache_addr_u  fetch_line;
   icache_addr_u  miss_line;

   // Hit check
   way_oh_t       way_match;
   logic          hit;
   line_t         hit_line;

   assign fetch_addr = fetch_addr_i;

   // Line bases for bypass reads and refills
   always_comb
   begin
      fetch_line          = fetch_addr;
      fetch_line.f.offset = '0;
      miss_line           = lookup_q;
      miss_line.f.offset  = '0;
   end

   ////////////////////////////////////////////////////////////
   // Tag compare and way mux
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      hit_line = '0;
      for (int w = 0; w < NB_WAYS; w++)
      begin
         way_match[w] = way_valid_i[w] && (way_tag_i[w] == lookup_q.f.tag);
         // At most one way matches
         if (way_match[w])
         begin
            hit_line = way_line_i[w];
         end
      end
   end

   assign hit = |way_match;

   // Refill always targets the missed set
   assign wr_way_o       = victim_way_i;
   assign wr_index_o     = lookup_q.f.index;
   assign wr_tag_o       = lookup_q.f.tag;
   assign wr_line_o      = fill.line;
   assign victim_valid_o = valid_snap_q;
   assign victim_take_o  = wr_en_o;

   ////////////////////////////////////////////////////////////
   // Bank FSM
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      state_d          = state_q;
      lookup_vld_d     = lookup_vld_q;
      refilled_d       = refilled_q;
      snap_valid       = 1'b0;
      cache_bypassed_o = 1'b1;
      fetch_gnt_o      = 1'b0;
      fetch_rvalid_o   = 1'b0;
      fetch_rdata_o    = fill.line;
      rd_en_o          = 1'b0;
      rd_index_o       = fetch_addr.f.index;
      wr_en_o          = 1'b0;
      flush_o          = 1'b0;
      fill.req         = 1'b0;
      fill.addr        = fetch_line;

      case (state_q)
         // Power-up mode, each fetch is a line read
         DISABLED:
         begin
            fetch_rvalid_o = fill.done;
            if (!bypass_i)
            begin
               state_d = WAIT_IDLE;
            end
            else
            begin
               fetch_gnt_o = fetch_req_i & ~fill.busy;
               fill.req    = fetch_gnt_o;
            end
         end

         // Drain the last bypass read, then invalidate everything
         WAIT_IDLE:
         begin
            fetch_rvalid_o = fill.done;
            if (!fill.busy)
            begin
               flush_o      = 1'b1;
               lookup_vld_d = 1'b0;
               refilled_d   = 1'b0;
               state_d      = OPERATIVE;
            end
         end

         OPERATIVE:
         begin
            cache_bypassed_o = 1'b0;
            fetch_rvalid_o   = lookup_vld_q & hit;
            fetch_rdata_o    = hit_line;
            if (lookup_vld_q && !hit)
            begin
               // Miss, keep the lookup and fetch the line
               snap_valid = 1'b1;
               state_d    = REQ_REFILL;
            end
            else
            begin
               // Empty or hit, a new fetch may enter
               fetch_gnt_o  = fetch_req_i & ~bypass_i;
               rd_en_o      = fetch_gnt_o;
               lookup_vld_d = fetch_gnt_o;
               if (bypass_i)
               begin
                  state_d = LEAVE_CACHE;
               end
            end
         end

         REQ_REFILL:
         begin
            cache_bypassed_o = 1'b0;
            fill.addr        = miss_line;
            fill.req         = ~fill.busy;
            if (!fill.busy)
            begin
               state_d = WAIT_REFILL;
            end
         end

         // Write the returned line, then repeat the lookup
         WAIT_REFILL:
         begin
            cache_bypassed_o = 1'b0;
            if (fill.done)
            begin
               wr_en_o    = 1'b1;
               refilled_d = 1'b1;
            end
            else if (refilled_q)
            begin
               rd_en_o    = 1'b1;
               rd_index_o = lookup_q.f.index;
               refilled_d = 1'b0;
               state_d    = OPERATIVE;
            end
         end

         LEAVE_CACHE:
         begin
            state_d = DISABLED;
         end

         default:
         begin
            state_d = DISABLED;
         end
      endcase
   end

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q      <= DISABLED;
         lookup_vld_q <= 1'b0;
         refilled_q   <= 1'b0;
      end
      else
      begin
         state_q      <= state_d;
         lookup_vld_q <= lookup_vld_d;
         refilled_q   <= refilled_d;
      end
   end

   // Lookup address and valid snapshot
   always_ff @(posedge clk)
   begin
      if (fetch_gnt_o)
      begin
         lookup_q <= fetch_addr;
      end
      if (snap_valid)
      begin
         valid_snap_q <= way_valid_i;
      end
   end

endmodule

`default_nettype wire

/* design/icache_pkg.sv */
`default_nettype none

package icache_pkg;

   // Bus and fetch geometry
   localparam int ADDR_W         = 32;
   localparam int LINE_W         = 128;
   localparam int WB_DATA_W      = 32;
   localparam int WORDS_PER_LINE = LINE_W / WB_DATA_W;

   // Cache organisation
   localparam int NB_WAYS        = 4;
   localparam int NB_SETS        = 16;

   // Address split
   localparam int OFFSET_W       = 4;
   localparam int INDEX_W        = 4;
   localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;

   // Field view of a fetch address
   typedef struct packed {
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;
   } icache_addr_s;

   // Same word seen as raw bus address or as tag/index/offset
   typedef union packed {
      logic [ADDR_W-1:0] raw;
      icache_addr_s      f;
   } icache_addr_u;

   // One bit per way, one-hot when selecting
   typedef logic [NB_WAYS-1:0] way_oh_t;

   // Full line, bus word 0 in the low bits
   typedef logic [LINE_W-1:0] line_t;

   // Bank controller states
   typedef enum logic [2:0] {
      DISABLED,
      WAIT_IDLE,
      OPERATIVE,
      REQ_REFILL,
      WAIT_REFILL,
      LEAVE_CACHE
   } icache_state_e;

endpackage

`default_nettype wire

/* design/icache_victim_sel.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_victim_sel
(
   input  logic                clk,
   input  logic                rst_n,
   input  icache_pkg::way_oh_t valid_i,
   input  logic                take_i,
   output icache_pkg::way_oh_t victim_way_o
);
   import icache_pkg::*;

   // Replacement LFSR, taps 8,6,5,4
   logic [7:0] lfsr_q;
   logic       feedback;
   logic       all_valid;

   assign all_valid = &valid_i;
   assign feedback  = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

   always_comb
   begin
      victim_way_o = '0;
      if (all_valid)
      begin
         // Random way from the low LFSR bits
         victim_way_o[lfsr_q[1:0]] = 1'b1;
      end
      else
      begin
         // Ascending scan, last invalid way wins
         for (int w = 0; w < NB_WAYS; w++)
         begin
            if (!valid_i[w])
            begin
               victim_way_o = way_oh_t'(1 << w);
            end
         end
      end
   end

   // Step only when the random choice was consumed
   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         lfsr_q <= 8'h5A;
      end
      else if (take_i && all_valid)
      begin
         lfsr_q <= {lfsr_q[6:0], feedback};
      end
   end

endmodule

`default_nettype wire

/* design/icache_wb_reader.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_wb_reader
(
   input  logic                             clk,
   input  logic                             rst_n,

   // Line requests from the controller
   line_fill_if.target                      fill,

   // Wishbone classic read master
   output logic                             wb_cyc_o,
   output logic                             wb_stb_o,
   output logic [icache_pkg::ADDR_W-1:0]    wb_adr_o,
   input  logic [icache_pkg::WB_DATA_W-1:0] wb_dat_i,
   input  logic                             wb_ack_i
);
   import icache_pkg::*;

   logic         busy_q;
   logic         cyc_q;
   logic         done_q;

   // Word within the line
   logic [1:0]   word_cnt_q;

   // Line base and assembled data
   icache_addr_u base_q;
   icache_addr_u word_addr;
   line_t        line_q;

   // Word address from the line base and the count
   always_comb
   begin
      word_addr          = base_q;
      word_addr.f.offset = {word_cnt_q, 2'b00};
   end

   assign wb_cyc_o  = cyc_q;
   assign wb_stb_o  = cyc_q;
   assign wb_adr_o  = word_addr.raw;

   assign fill.busy = busy_q;
   assign fill.done = done_q;
   assign fill.line = line_q;

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         busy_q     <= 1'b0;
         cyc_q      <= 1'b0;
         done_q     <= 1'b0;
         word_cnt_q <= '0;
      end
      else
      begin
         done_q <= 1'b0;
         if (!busy_q)
         begin
            if (fill.req)
            begin
               busy_q     <= 1'b1;
               cyc_q      <= 1'b1;
               word_cnt_q <= '0;
            end
         end
         // Busy falls right after the done cycle
         else if (done_q)
         begin
            busy_q <= 1'b0;
         end
         else if (cyc_q && wb_ack_i)
         begin
            word_cnt_q <= word_cnt_q + 2'd1;
            // Last word ends the cycle
            if (word_cnt_q == 2'(WORDS_PER_LINE - 1))
            begin
               cyc_q  <= 1'b0;
               done_q <= 1'b1;
            end
         end
      end
   end

   // Request address and line assembly
   always_ff @(posedge clk)
   begin
      if (!busy_q && fill.req)
      begin
         base_q <= fill.addr;
      end
      if (cyc_q && wb_ack_i)
      begin
         line_q[word_cnt_q*WB_DATA_W +: WB_DATA_W] <= wb_dat_i;
      end
   end

endmodule

`default_nettype wire

/* design/line_fill_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface line_fill_if;
   import icache_pkg::*;

   // Line read request, line-aligned address
   logic         req;
   icache_addr_u addr;

   // Reader status and returned line
   logic         busy;
   logic         done;
   line_t        line;

   // Controller side
   modport initiator (output req, output addr, input busy, input done, input line);

   // Bus reader side
   modport target (input req, input addr, output busy, output done, output line);

endinterface

`default_nettype wire

/* sim.f */
design/icache_pkg.sv
design/line_fill_if.sv
design/icache_arrays.sv
design/icache_victim_sel.sv
design/icache_ctrl.sv
design/icache_wb_reader.sv
design/icache_bank.sv
tests/icache_bank_asserts.sv
tests/icache_bank_tb.sv

/* tests/icache_bank_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_bank_asserts
(
   input  logic                          clk,
   input  logic                          rst_n,

   // Wishbone master side
   input  logic                          cyc_i,
   input  logic                          stb_i,
   input  logic                          ack_i,
   input  logic [icache_pkg::ADDR_W-1:0] adr_i,

   // Fetch handshake
   input  logic                          gnt_i,
   input  logic                          req_i,

   // Line reader status
   input  logic                          done_i,
   input  logic                          busy_i
);

   // Per-property failure counts, summed for the testbench
   int stb_fails  = 0;
   int hold_fails = 0;
   int gnt_fails  = 0;
   int done_fails = 0;
   int fail_count;

   assign fail_count = stb_fails + hold_fails + gnt_fails + done_fails;

   ////////////////////////////////////////////////////////////
   // Bus protocol
   ////////////////////////////////////////////////////////////

   // Strobe and word address stay put until the slave acks
   stb_hold: assert property (@(posedge clk) disable iff (!rst_n)
                              stb_i && !ack_i |=> stb_i && $stable(adr_i))
   else
   begin
      $error("wb_stb_o or wb_adr_o changed before wb_ack_i");
      stb_fails++;
   end

   // A started cycle stays open until acked
   cyc_hold: assert property (@(posedge clk) disable iff (!rst_n) cyc_i && !ack_i |=> cyc_i)
   else
   begin
      $error("wb_cyc_o dropped before wb_ack_i");
      hold_fails++;
   end

   ////////////////////////////////////////////////////////////
   // Fetch and line reader handshakes
   ////////////////////////////////////////////////////////////

   // Grant needs a request and a reader with no line in progress
   gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
                                   gnt_i |-> req_i && !busy_i)
   else
   begin
      $error("fetch_gnt_o without fetch_req_i or while the line reader is busy");
      gnt_fails++;
   end

   done_in_busy: assert property (@(posedge clk) disable iff (!rst_n) done_i |-> busy_i)
   else
   begin
      $error("line done pulse while reader idle");
      done_fails++;
   end

endmodule

// Fetch handshake lives in the controller, reader status seen through its port
bind icache_ctrl icache_bank_asserts u_ctrl_asserts
(
   .clk    ( clk         ),
   .rst_n  ( rst_n       ),
   .cyc_i  ( 1'b0        ),
   .stb_i  ( 1'b0        ),
   .ack_i  ( 1'b0        ),
   .adr_i  ( '0          ),
   .gnt_i  ( fetch_gnt_o ),
   .req_i  ( fetch_req_i ),
   .done_i ( fill.done   ),
   .busy_i ( fill.busy   )
);

// Bus and line status live in the reader
bind icache_wb_reader icache_bank_asserts u_reader_asserts
(
   .clk    ( clk      ),
   .rst_n  ( rst_n    ),
   .cyc_i  ( wb_cyc_o ),
   .stb_i  ( wb_stb_o ),
   .ack_i  ( wb_ack_i ),
   .adr_i  ( wb_adr_o ),
   .gnt_i  ( 1'b0     ),
   .req_i  ( 1'b0     ),
   .done_i ( done_q   ),
   .busy_i ( busy_q   )
);

`default_nettype wire

/* tests/icache_bank_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_bank_tb;
   import icache_pkg::*;

   localparam int         WAIT_LIMIT = 200;
   // Either a hit or a refill is legal
   localparam logic [2:0] WORDS_ANY  = 3'd7;

   // One stimulus row, words is the expected bus cost of the fetch
   typedef struct packed {
      logic        bypass;
      logic [31:0] addr;
      logic [2:0]  words;
   } row_t;

   logic                 clk = 1'b0;
   logic                 rst_n;
   logic                 bypass;
   logic                 cache_bypassed;
   logic                 fetch_req;
   logic [ADDR_W-1:0]    fetch_addr;
   logic                 fetch_gnt;
   logic                 fetch_rvalid;
   line_t                fetch_rdata;
   logic                 wb_cyc;
   logic                 wb_stb;
   logic [ADDR_W-1:0]    wb_adr;
   logic [WB_DATA_W-1:0] wb_dat = '0;
   logic                 wb_ack = 1'b0;

   // Memory model state
   logic [31:0]          rng_state  = 32'd98;
   logic [1:0]           wait_left  = 2'd0;
   logic                 wait_armed = 1'b0;
   int                   words_read = 0;

   row_t                 rows[$];
   int                   check_fails = 0;
   logic                 timed_out   = 1'b0;

   always #2 clk = ~clk;

   icache_bank u_dut
   (
      .clk              ( clk            ),
      .rst_n            ( rst_n          ),
      .bypass_i         ( bypass         ),
      .cache_bypassed_o ( cache_bypassed ),
      .fetch_req_i      ( fetch_req      ),
      .fetch_addr_i     ( fetch_addr     ),
      .fetch_gnt_o      ( fetch_gnt      ),
      .fetch_rvalid_o   ( fetch_rvalid   ),
      .fetch_rdata_o    ( fetch_rdata    ),
      .wb_cyc_o         ( wb_cyc         ),
      .wb_stb_o         ( wb_stb         ),
      .wb_adr_o         ( wb_adr         ),
      .wb_dat_i         ( wb_dat         ),
      .wb_ack_i         ( wb_ack         )
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x;
      y = y ^ (y << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Memory holds address XOR a constant, so a line follows from its base
   function automatic line_t model_line(input logic [31:0] addr);
      line_t       l;
      logic [31:0] base;
      base = {addr[31:4], 4'b0000};
      for (int i = 0; i < WORDS_PER_LINE; i++)
      begin
         l[i*WB_DATA_W +: WB_DATA_W] = (base + 32'(i * 4)) ^ 32'hA5A5_0000;
      end
      return l;
   endfunction

   ////////////////////////////////////////////////////////////
   // Wishbone memory model, 0 to 3 wait cycles per word
   ////////////////////////////////////////////////////////////

   always @(posedge clk)
   begin
      #0.5;
      // The reader took the previous ack at this edge
      if (wb_ack)
      begin
         wb_ack     = 1'b0;
         words_read = words_read + 1;
      end
      if (wb_cyc && wb_stb)
      begin
         if (!wait_armed)
         begin
            rng_state  = xorshift32(rng_state);
            wait_left  = rng_state[1:0];
            wait_armed = 1'b1;
         end
         if (wait_left == 2'd0)
         begin
            wb_ack     = 1'b1;
            wb_dat     = wb_adr ^ 32'hA5A5_0000;
            wait_armed = 1'b0;
         end
         else
         begin
            wait_left = wait_left - 2'd1;
         end
      end
   end

   task automatic check_line(input string name, input line_t expected, input line_t actual);
      assert (actual === expected)
      else
      begin
         $display("Fail at %t: %s expected %h, got %h", $time, name, expected, actual);
         check_fails++;
      end
   endtask

   task automatic check_int(input string name, input int expected, input int actual);
      assert (actual === expected)
      else
      begin
         $display("Fail at %t: %s expected %0d, got %0d", $time, name, expected, actual);
         check_fails++;
      end
   endtask

   function automatic void add_row(input logic mode, input logic [31:0] addr,
                                   input logic [2:0] words);
      rows.push_back({mode, addr, words});
   endfunction

   // Change mode and wait for the bank to follow
   task automatic set_mode(input logic mode);
      int cycles;
      cycles = 0;
      bypass = mode;
      @(negedge clk);
      while (cache_bypassed !== mode && cycles < WAIT_LIMIT)
      begin
         cycles++;
         @(negedge clk);
      end
      assert (cache_bypassed === mode)
      else
      begin
         $display("Timeout: cache_bypassed_o did not follow bypass_i = %b", mode);
         timed_out = 1'b1;
      end
      @(posedge clk);
      #0.5;
   endtask

   // One fetch, starts and ends just after a rising edge
   task automatic run_fetch(input logic [31:0] addr, output line_t data, output int latency,
                            output int words);
      int cycles;
      int start_words;
      cycles      = 0;
      latency     = 0;
      words       = 0;
      data        = '0;
      start_words = words_read;
      fetch_req   = 1'b1;
      fetch_addr  = addr;
      // Grant is combinational, so look mid-cycle
      @(negedge clk);
      while (fetch_gnt !== 1'b1 && cycles < WAIT_LIMIT)
      begin
         cycles++;
         @(negedge clk);
      end
      if (fetch_gnt !== 1'b1)
      begin
         $display("Timeout: no grant for fetch address %h", addr);
         timed_out = 1'b1;
         return;
      end
      @(posedge clk);
      #0.5;
      fetch_req = 1'b0;
      // Latency counted in cycles after the grant edge
      latency = 1;
      @(negedge clk);
      while (fetch_rvalid !== 1'b1 && latency < WAIT_LIMIT)
      begin
         latency++;
         @(negedge clk);
      end
      if (fetch_rvalid !== 1'b1)
      begin
         $display("Timeout: no read data for fetch address %h", addr);
         timed_out = 1'b1;
         return;
      end
      data  = fetch_rdata;
      words = words_read - start_words;
      @(posedge clk);
      #0.5;
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////////////////////////

   function automatic void fill_table();
      // Bypass, every fetch is a line read
      add_row(1'b1, 32'h0000_1000, 3'd4);
      add_row(1'b1, 32'h0000_2344, 3'd4);
      add_row(1'b1, 32'h0000_1000, 3'd4);
      // Cached, miss then hits on the same line
      add_row(1'b0, 32'h0000_0100, 3'd4);
      add_row(1'b0, 32'h0000_0108, 3'd0);
      add_row(1'b0, 32'h0000_0100, 3'd0);
      // Four tags in set 3 fill the four ways
      add_row(1'b0, 32'h0000_1030, 3'd4);
      add_row(1'b0, 32'h0000_2030, 3'd4);
      add_row(1'b0, 32'h0000_3030, 3'd4);
      add_row(1'b0, 32'h0000_4030, 3'd4);
      add_row(1'b0, 32'h0000_1034, 3'd0);
      add_row(1'b0, 32'h0000_2038, 3'd0);
      add_row(1'b0, 32'h0000_303C, 3'd0);
      add_row(1'b0, 32'h0000_4030, 3'd0);
      // Fifth tag evicts a random way
      add_row(1'b0, 32'h0000_5030, 3'd4);
      add_row(1'b0, 32'h0000_1030, WORDS_ANY);
      add_row(1'b0, 32'h0000_2030, WORDS_ANY);
      add_row(1'b0, 32'h0000_3030, WORDS_ANY);
      add_row(1'b0, 32'h0000_4030, WORDS_ANY);
      add_row(1'b0, 32'h0000_5030, WORDS_ANY);
      // Back to bypass
      add_row(1'b1, 32'h0000_0100, 3'd4);
      add_row(1'b1, 32'h0000_1030, 3'd4);
      // Re-enable flushed everything
      add_row(1'b0, 32'h0000_0100, 3'd4);
      add_row(1'b0, 32'h0000_0104, 3'd0);
      add_row(1'b0, 32'h0000_2030, 3'd4);
   endfunction

   initial
   begin
      line_t data;
      row_t  row;
      int    latency;
      int    words;
      int    fails_before;
      int    tests_run;
      int    tests_bad;
      int    assert_fails;
      $timeformat(-9, 2, " ns", 0);
      tests_run  = 0;
      tests_bad  = 0;
      rst_n      = 1'b0;
      bypass     = 1'b1;
      fetch_req  = 1'b0;
      fetch_addr = '0;
      fill_table();

      repeat (2) @(posedge clk);
      #0.5;
      rst_n = 1'b1;

      // Power-up state is bypassed and idle
      @(negedge clk);
      check_int("cache_bypassed_o", 1, int'(cache_bypassed));
      check_int("fetch_rvalid_o", 0, int'(fetch_rvalid));
      check_int("wb_cyc_o", 0, int'(wb_cyc));
      check_int("wb_stb_o", 0, int'(wb_stb));
      $display("Reset state: %s", (check_fails == 0) ? "ok" : "error");
      @(posedge clk);
      #0.5;

      for (int i = 0; i < rows.size() && !timed_out; i++)
      begin
         row          = rows[i];
         fails_before = check_fails;
         if (row.bypass !== bypass)
         begin
            set_mode(row.bypass);
         end
         if (!timed_out)
         begin
            run_fetch(row.addr, data, latency, words);
         end
         if (!timed_out)
         begin
            check_line("fetch_rdata_o", model_line(row.addr), data);
            if (row.words == WORDS_ANY)
            begin
               assert (words == 0 || words == 4)
               else
               begin
                  $display("Fail at %t: bus words expected 0 or 4, got %0d", $time, words);
                  check_fails++;
               end
            end
            else
            begin
               check_int("bus words", int'(row.words), words);
            end
            // A hit answers one cycle after its grant
            if (row.words == 3'd0)
            begin
               check_int("fetch_rvalid_o latency", 1, latency);
            end
            tests_run++;
            if (check_fails != fails_before)
            begin
               tests_bad++;
            end
            $display("Test %0d bypass %b addr %h: %0d bus words, latency %0d, %s",
                     i, row.bypass, row.addr, words, latency,
                     (check_fails == fails_before) ? "ok" : "error");
         end
      end

      assert_fails = u_dut.u_ctrl.u_ctrl_asserts.fail_count
                   + u_dut.u_wb_reader.u_reader_asserts.fail_count;
      $display("Tests run %0d, with errors %0d, failed checks %0d, assertion failures %0d",
               tests_run, tests_bad, check_fails, assert_fails);
      if (!timed_out && check_fails == 0 && assert_fails == 0)
      begin
         $display("All tests passed");
      end
      else
      begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
